/* calc_core.f */
source/calc_pkg.sv
source/mod_addsub_lane.sv
source/reg_file.sv
source/calc_sequencer.sv
source/calc_core.sv
tb/clk_gen.sv
tb/calc_core_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f calc_core.f --top-module calc_core_tb -o sim_calc_core \
	&& ./obj_dir/sim_calc_core | tee /dev/stderr | grep -q "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation did not pass"; exit 1; }

exit 0

/* source/calc_core.sv */
`timescale 1ns/1ps

module calc_core #(
	parameter int LANES = 8,
	parameter int MODULUS = 65521
) (
	input logic clk,
	input logic rst_n,
	input calc_pkg::host_mode_e host_mode,
	input calc_pkg::cmd_t cmd,
	input calc_pkg::addr_t waddr1,
	input calc_pkg::addr_t waddr2,
	input calc_pkg::addr_t raddr1,
	input calc_pkg::addr_t raddr2,
	input calc_pkg::word_t wdata1,
	input calc_pkg::word_t wdata2,
	output calc_pkg::word_t outdata1,
	output calc_pkg::word_t outdata2,
	output logic finished
);
	import calc_pkg::*;

	addr_t opr1_base;
	addr_t opr2_base;
	addr_t ret_base;
	word_t opr1_words [LANES];
	word_t opr2_words [LANES];
	lane_op_t lane_ops [LANES];
	lane_res_t lane_res [LANES];

	// decode, dispatch and finished flag
	calc_sequencer #(.LANES(LANES)) seq_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_mode(host_mode),
		.cmd(cmd),
		.opr1_base(opr1_base),
		.opr2_base(opr2_base),
		.opr1_words(opr1_words),
		.opr2_words(opr2_words),
		.lane_ops(lane_ops),
		.ret_base(ret_base),
		.finished(finished)
	);

	// lanes run side by side, one register stage each
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		mod_addsub_lane #(.MODULUS(MODULUS)) lane_i (
			.clk(clk),
			.rst_n(rst_n),
			.op(lane_ops[g]),
			.res(lane_res[g])
		);
	end

	reg_file #(.LANES(LANES)) rf_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_mode(host_mode),
		.waddr1(waddr1),
		.waddr2(waddr2),
		.wdata1(wdata1),
		.wdata2(wdata2),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.outdata1(outdata1),
		.outdata2(outdata2),
		.opr1_base(opr1_base),
		.opr2_base(opr2_base),
		.opr1_words(opr1_words),
		.opr2_words(opr2_words),
		.lane_res(lane_res),
		.ret_base(ret_base)
	);

endmodule

/* source/calc_pkg.sv */
package calc_pkg;

	// field word and register file geometry
	localparam int WORD_W = 16;
	localparam int ADDR_W = 6;
	localparam int MODE_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// command word, mode in the top bits
	typedef struct packed {
		logic [MODE_W-1:0] mode;
		addr_t opr1;
		addr_t opr2;
		addr_t ret;
	} cmd_t;

	// level-coded host mode
	typedef enum logic [1:0] {
		host_idle = 2'd0,
		host_exec = 2'd1,
		host_load = 2'd2,
		host_read = 2'd3
	} host_mode_e;

	// vector commands, other codes finish without a write
	typedef enum logic [MODE_W-1:0] {
		mode_vadd = 4'd1,
		mode_vsub = 4'd2,
		mode_vneg = 4'd3
	} calc_mode_e;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_wait,
		st_done
	} seq_state_e;

	// one operation handed to a lane
	typedef struct packed {
		logic valid;
		logic is_sub;
		word_t a;
		word_t b;
	} lane_op_t;

	typedef struct packed {
		logic valid;
		word_t result;
	} lane_res_t;

endpackage

/* source/calc_sequencer.sv */
`timescale 1ns/1ps

module calc_sequencer #(
	parameter int LANES = 8
) (
	input logic clk,
	input logic rst_n,
	input calc_pkg::host_mode_e host_mode,
	input calc_pkg::cmd_t cmd,
	output calc_pkg::addr_t opr1_base,
	output calc_pkg::addr_t opr2_base,
	input calc_pkg::word_t opr1_words [LANES],
	input calc_pkg::word_t opr2_words [LANES],
	output calc_pkg::lane_op_t lane_ops [LANES],
	output calc_pkg::addr_t ret_base,
	output logic finished
);
	import calc_pkg::*;

	seq_state_e state;
	logic start;
	logic nxt_valid;
	logic nxt_sub;
	logic is_neg;
	word_t nxt_a [LANES];
	word_t nxt_b [LANES];
	logic op_valid_q;
	logic op_sub_q;
	word_t op_a_q [LANES];
	word_t op_b_q [LANES];

	// windows follow the command directly
	assign opr1_base = cmd.opr1;
	assign opr2_base = cmd.opr2;

	assign start = (state == st_idle) && (host_mode == host_exec);
	assign is_neg = (cmd.mode == mode_vneg);

	// decode
	always_comb begin
		nxt_valid = 1'b1;
		nxt_sub = 1'b0;
		case (calc_mode_e'(cmd.mode))
			mode_vadd: nxt_sub = 1'b0;
			mode_vsub: nxt_sub = 1'b1;
			mode_vneg: nxt_sub = 1'b1;
			// unknown code runs the states with nothing issued
			default: nxt_valid = 1'b0;
		endcase
		for (int i = 0; i < LANES; i++) begin
			// negate is zero minus operand 1
			nxt_a[i] = is_neg ? '0 : opr1_words[i];
			nxt_b[i] = is_neg ? opr1_words[i] : opr2_words[i];
		end
	end

	// state and issue strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			op_valid_q <= 1'b0;
		end else begin
			op_valid_q <= start && nxt_valid;
			if (host_mode != host_exec)
				state <= st_idle;
			else begin
				case (state)
					st_idle: state <= st_issue;
					st_issue: state <= st_wait;
					st_wait: state <= st_done;
					default: state <= st_done;
				endcase
			end
		end
	end

	// operands and return base captured once per command
	always_ff @(posedge clk) begin
		if (start) begin
			op_sub_q <= nxt_sub;
			ret_base <= cmd.ret;
			for (int i = 0; i < LANES; i++) begin
				op_a_q[i] <= nxt_a[i];
				op_b_q[i] <= nxt_b[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			lane_ops[i] = '{valid: op_valid_q, is_sub: op_sub_q, a: op_a_q[i], b: op_b_q[i]};
		end
	end

	assign finished = (state == st_done);

	// host still in execute when finished first shows up
	a_fin_exec: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(finished) |-> (host_mode == host_exec));

endmodule

/* source/mod_addsub_lane.sv */
`timescale 1ns/1ps

module mod_addsub_lane #(
	parameter int MODULUS = 65521
) (
	input logic clk,
	input logic rst_n,
	input calc_pkg::lane_op_t op,
	output calc_pkg::lane_res_t res
);
	import calc_pkg::*;

	// one extra bit for the carry and the borrow
	localparam logic [WORD_W:0] mod_ext = (WORD_W+1)'(MODULUS);

	logic [WORD_W:0] sum;
	logic [WORD_W:0] diff;
	logic [WORD_W:0] nxt;
	logic valid_q;
	word_t result_q;

	always_comb begin
		sum = {1'b0, op.a} + {1'b0, op.b};
		diff = {1'b0, op.a} - {1'b0, op.b};
		if (op.is_sub)
			// borrow wraps, adding the modulus brings it back in range
			nxt = (op.a < op.b) ? diff + mod_ext : diff;
		else
			nxt = (sum >= mod_ext) ? sum - mod_ext : sum;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_q <= 1'b0;
		else
			valid_q <= op.valid;
	end

	always_ff @(posedge clk) begin
		result_q <= nxt[WORD_W-1:0];
	end

	assign res = '{valid: valid_q, result: result_q};

	a_reduced: assert property (@(posedge clk) disable iff (!rst_n)
		res.valid |-> (res.result < MODULUS));

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
	parameter int LANES = 8
) (
	input logic clk,
	input logic rst_n,
	input calc_pkg::host_mode_e host_mode,
	input calc_pkg::addr_t waddr1,
	input calc_pkg::addr_t waddr2,
	input calc_pkg::word_t wdata1,
	input calc_pkg::word_t wdata2,
	input calc_pkg::addr_t raddr1,
	input calc_pkg::addr_t raddr2,
	output calc_pkg::word_t outdata1,
	output calc_pkg::word_t outdata2,
	input calc_pkg::addr_t opr1_base,
	input calc_pkg::addr_t opr2_base,
	output calc_pkg::word_t opr1_words [LANES],
	output calc_pkg::word_t opr2_words [LANES],
	input calc_pkg::lane_res_t lane_res [LANES],
	input calc_pkg::addr_t ret_base
);
	import calc_pkg::*;

	word_t mem [2**ADDR_W];
	logic lane_wr_any;

	// operand windows, addresses wrap around the file
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			opr1_words[i] = mem[addr_t'(opr1_base + i)];
			opr2_words[i] = mem[addr_t'(opr2_base + i)];
		end
	end

	always_comb begin
		lane_wr_any = 1'b0;
		for (int i = 0; i < LANES; i++) begin
			lane_wr_any = lane_wr_any | lane_res[i].valid;
		end
	end

	// storage, host load then lane write-back
	always_ff @(posedge clk) begin
		if (host_mode == host_load) begin
			mem[waddr1] <= wdata1;
			// second port lands last, wins on equal addresses
			mem[waddr2] <= wdata2;
		end
		for (int i = 0; i < LANES; i++) begin
			if (lane_res[i].valid)
				mem[addr_t'(ret_base + i)] <= lane_res[i].result;
		end
	end

	// registered host read, held outside read mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outdata1 <= '0;
			outdata2 <= '0;
		end else if (host_mode == host_read) begin
			outdata1 <= mem[raddr1];
			outdata2 <= mem[raddr2];
		end
	end

	// results only come back while the host keeps its hands off the file
	a_no_wr_clash: assert property (@(posedge clk) disable iff (!rst_n)
		!(lane_wr_any && host_mode == host_load));

endmodule

/* tb/calc_core_tb.sv */
`timescale 1ns/1ps

module calc_core_tb;
	import calc_pkg::*;

	localparam int LANES = 8;
	localparam int MODULUS = 65521;
	localparam int MAX_CYCLES = 2000;

	logic clk;
	logic rst_n;
	host_mode_e host_mode;
	cmd_t cmd;
	addr_t waddr1;
	addr_t waddr2;
	addr_t raddr1;
	addr_t raddr2;
	word_t wdata1;
	word_t wdata2;
	word_t outdata1;
	word_t outdata2;
	logic finished;

	// shadow copy of the register file
	word_t shadow [64];
	// expected host read outputs, follow the read port
	word_t exp1_q;
	word_t exp2_q;
	// consecutive execute edges, saturates at 3
	logic [1:0] exec_cnt;
	int cycles = 0;

	clk_gen #(.PERIOD(8.0), .RST_CYCLES(10)) clk_gen_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	calc_core #(.LANES(LANES), .MODULUS(MODULUS)) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.host_mode(host_mode),
		.cmd(cmd),
		.waddr1(waddr1),
		.waddr2(waddr2),
		.raddr1(raddr1),
		.raddr2(raddr2),
		.wdata1(wdata1),
		.wdata2(wdata2),
		.outdata1(outdata1),
		.outdata2(outdata2),
		.finished(finished)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	// field result straight from the command definitions
	function automatic word_t field_result(input logic [3:0] code, input word_t a, input word_t b);
		int r;
		case (code)
			4'd1: r = (int'(a) + int'(b)) % MODULUS;
			4'd2: r = (int'(a) - int'(b) + MODULUS) % MODULUS;
			default: r = (MODULUS - int'(a)) % MODULUS;
		endcase
		return word_t'(r);
	endfunction

	// read model, one cycle latency, holds outside read mode
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp1_q <= '0;
			exp2_q <= '0;
		end else if (host_mode == host_read) begin
			exp1_q <= shadow[raddr1];
			exp2_q <= shadow[raddr2];
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			exec_cnt <= 2'd0;
		else if (host_mode != host_exec)
			exec_cnt <= 2'd0;
		else if (exec_cnt != 2'd3)
			exec_cnt <= exec_cnt + 2'd1;
	end

	// checks sit on the falling edge, away from the drive point
	a_out1: assert property (@(negedge clk) outdata1 == exp1_q)
		else stop_on_error($sformatf("Fail %0t outdata1 got %h expected %h",
			$time, outdata1, exp1_q));

	a_out2: assert property (@(negedge clk) outdata2 == exp2_q)
		else stop_on_error($sformatf("Fail %0t outdata2 got %h expected %h",
			$time, outdata2, exp2_q));

	// high from the third execute edge on, low otherwise and in reset
	a_finished: assert property (@(negedge clk) finished == (exec_cnt == 2'd3))
		else stop_on_error($sformatf("Fail %0t finished got %b expected %b",
			$time, finished, exec_cnt == 2'd3));

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			stop_on_error("timeout, the run did not end within the cycle limit");
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic load_pair(input addr_t a1, input word_t d1, input addr_t a2, input word_t d2);
		next_cycle();
		host_mode = host_load;
		waddr1 = a1;
		wdata1 = d1;
		waddr2 = a2;
		wdata2 = d2;
		shadow[a1] = d1;
		// port 2 lands last
		shadow[a2] = d2;
	endtask

	task automatic load_all();
		for (int i = 0; i < 32; i++) begin
			load_pair(addr_t'(2 * i), word_t'($urandom % MODULUS),
				addr_t'(2 * i + 1), word_t'($urandom % MODULUS));
		end
	endtask

	// evens on port 1, odds on port 2, whole file covered
	task automatic read_back_all();
		for (int i = 0; i < 32; i++) begin
			next_cycle();
			host_mode = host_read;
			raddr1 = addr_t'(2 * i);
			raddr2 = addr_t'(63 - 2 * i);
		end
		next_cycle();
		host_mode = host_idle;
	endtask

	task automatic run_cmd(input logic [3:0] code, input addr_t o1, input addr_t o2,
		input addr_t r);
		word_t res [LANES];
		logic known;
		known = (code >= 4'd1) && (code <= 4'd3);
		// results from the file as it stands before the command
		for (int i = 0; i < LANES; i++) begin
			res[i] = field_result(code, shadow[addr_t'(o1 + i)], shadow[addr_t'(o2 + i)]);
		end
		next_cycle();
		host_mode = host_exec;
		cmd = '{mode: code, opr1: o1, opr2: o2, ret: r};
		@(negedge clk);
		while (!finished)
			@(negedge clk);
		// keep execute a few edges, finished must hold
		repeat (3) next_cycle();
		if (known) begin
			for (int i = 0; i < LANES; i++)
				shadow[addr_t'(r + i)] = res[i];
		end
		host_mode = host_idle;
	endtask

	initial begin
		host_mode = host_idle;
		cmd = '0;
		waddr1 = '0;
		waddr2 = '0;
		raddr1 = '0;
		raddr2 = '0;
		wdata1 = '0;
		wdata2 = '0;
		void'($urandom(11));
		@(posedge rst_n);
		repeat (2) next_cycle();

		load_all();
		// same address on both ports
		load_pair(6'd5, 16'h1234, 6'd5, 16'h4321);
		read_back_all();

		// vadd, random bases, windows may wrap
		for (int n = 0; n < 3; n++) begin
			run_cmd(4'd1, addr_t'($urandom), addr_t'($urandom), addr_t'($urandom));
			read_back_all();
		end

		// vsub, a few lanes forced to a < b
		load_pair(6'd40, 16'd3, 6'd48, 16'd9000);
		load_pair(6'd41, 16'd0, 6'd49, 16'd65520);
		run_cmd(4'd2, 6'd40, 6'd48, 6'd20);
		read_back_all();
		run_cmd(4'd2, addr_t'($urandom), addr_t'($urandom), addr_t'($urandom));
		read_back_all();

		// vneg over a wrapping window with zeros in it
		load_pair(6'd60, 16'd0, 6'd62, 16'd1);
		load_pair(6'd0, 16'd0, 6'd1, 16'd65520);
		run_cmd(4'd3, 6'd58, 6'd0, 6'd10);
		read_back_all();

		// unknown code, nothing written
		run_cmd(4'd9, 6'd0, 6'd8, 6'd16);
		read_back_all();

		$display("Test OK");
		$finish;
	end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
	parameter real PERIOD = 8.0,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// reset held low for a fixed number of edges, released off the edge
	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule
